// File: common/axi_regs_pkg.sv
/*
  bus widths, response codes and the register map of the SPI host
  imported by the AXI4-Lite slave, the register file and the top level
*/
`default_nettype none

package axi_regs_pkg;

  // bus geometry
  localparam int axi_data_w = 32;
  localparam int axi_addr_w = 11;

  typedef logic [axi_data_w-1:0] axi_data_t;
  typedef logic [axi_addr_w-1:0] axi_addr_t;
  typedef logic [1:0]            axi_resp_t;

  // only OKAY is ever returned
  localparam axi_resp_t resp_okay = 2'b00;

  // register index, word address bits 5:2
  typedef logic [3:0] reg_idx_t;

  localparam reg_idx_t reg_spi_wr         = 4'd0;
  localparam reg_idx_t reg_spi_address    = 4'd1;
  localparam reg_idx_t reg_spi_data_len   = 4'd2;
  localparam reg_idx_t reg_spi_write_data = 4'd4;
  localparam reg_idx_t reg_spi_read_data  = 4'd5;
  localparam reg_idx_t reg_clock_divide   = 4'd6;
  localparam reg_idx_t reg_spi_done       = 4'd8;

  // one accepted full-strobe write
  typedef struct packed {
    logic      valid;
    reg_idx_t  idx;
    axi_data_t data;
  } reg_wr_t;

  // one accepted read
  typedef struct packed {
    logic     valid;
    reg_idx_t idx;
  } reg_rd_t;

endpackage

`default_nettype wire

// File: common/spi_pkg.sv
/*
  SPI transfer fields, the transfer descriptor and FIFO sizing
  shared by the register file, the shift engine, the clock divider and the FIFOs
*/
`default_nettype none

package spi_pkg;

  // transfer fields as software writes them
  typedef logic [9:0] spi_addr_t;
  typedef logic [7:0] spi_len_t;
  typedef logic [4:0] clk_div_t;

  // descriptor latched at start, stable for the whole transfer
  typedef struct packed {
    logic      wnr;
    spi_addr_t addr;
    spi_len_t  data_len;
  } spi_desc_t;

  // header is the direction bit followed by the address
  localparam int hdr_bits = 1 + $bits(spi_addr_t);

  // counts bits inside one 32-bit word
  typedef logic [4:0] bit_cnt_t;

  // FIFO sizing
  localparam int fifo_depth = 16;
  typedef logic [3:0] fifo_ptr_t;

endpackage

`default_nettype wire

// File: rtl/axi_lite_slave.sv
/*
  AXI4-Lite slave front end
  turns bus handshakes into single-cycle register write and read strobes
*/
`timescale 1ns/1ps
`default_nettype none

module axi_lite_slave (
  input  logic                                S_AXI_ACLK,
  input  logic                                S_AXI_ARESETN,
  input  axi_regs_pkg::axi_addr_t             S_AXI_AWADDR,
  input  logic [2:0]                          S_AXI_AWPROT,
  input  logic                                S_AXI_AWVALID,
  output logic                                S_AXI_AWREADY,
  input  axi_regs_pkg::axi_data_t             S_AXI_WDATA,
  input  logic [axi_regs_pkg::axi_data_w/8-1:0] S_AXI_WSTRB,
  input  logic                                S_AXI_WVALID,
  output logic                                S_AXI_WREADY,
  output axi_regs_pkg::axi_resp_t             S_AXI_BRESP,
  output logic                                S_AXI_BVALID,
  input  logic                                S_AXI_BREADY,
  input  axi_regs_pkg::axi_addr_t             S_AXI_ARADDR,
  input  logic [2:0]                          S_AXI_ARPROT,
  input  logic                                S_AXI_ARVALID,
  output logic                                S_AXI_ARREADY,
  output axi_regs_pkg::axi_data_t             S_AXI_RDATA,
  output axi_regs_pkg::axi_resp_t             S_AXI_RRESP,
  output logic                                S_AXI_RVALID,
  input  logic                                S_AXI_RREADY,
  input  axi_regs_pkg::axi_data_t             rd_data,
  output axi_regs_pkg::reg_wr_t               reg_wr,
  output axi_regs_pkg::reg_rd_t               reg_rd
);
  import axi_regs_pkg::*;

  // address and data channels are accepted together
  logic wr_ready;
  logic aw_hs;
  logic ar_hs;

  assign S_AXI_AWREADY = wr_ready;
  assign S_AXI_WREADY  = wr_ready;
  assign S_AXI_BRESP   = resp_okay;
  assign S_AXI_RRESP   = resp_okay;

  assign aw_hs = wr_ready && S_AXI_AWVALID && S_AXI_WVALID;
  assign ar_hs = S_AXI_ARREADY && S_AXI_ARVALID;

  // partial strobes still complete on the bus but never reach the registers
  assign reg_wr = '{valid: aw_hs && (&S_AXI_WSTRB),
                    idx:   S_AXI_AWADDR[5:2],
                    data:  S_AXI_WDATA};

  // read index is presented in the accept cycle, data comes back muxed
  assign reg_rd = '{valid: ar_hs, idx: S_AXI_ARADDR[5:2]};

  ////////////////////////////////////////////////////////////
  // write channel
  ////////////////////////////////////////////////////////////

  always_ff @(posedge S_AXI_ACLK) begin
    if (!S_AXI_ARESETN) begin
      wr_ready     <= 1'b0;
      S_AXI_BVALID <= 1'b0;
    end else begin
      // one-cycle ready pulse, held off while a response is pending
      wr_ready <= S_AXI_AWVALID && S_AXI_WVALID && !S_AXI_BVALID && !wr_ready;
      if (aw_hs) begin
        S_AXI_BVALID <= 1'b1;
      end else if (S_AXI_BREADY) begin
        S_AXI_BVALID <= 1'b0;
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // read channel
  ////////////////////////////////////////////////////////////

  always_ff @(posedge S_AXI_ACLK) begin
    if (!S_AXI_ARESETN) begin
      S_AXI_ARREADY <= 1'b0;
      S_AXI_RVALID  <= 1'b0;
    end else begin
      S_AXI_ARREADY <= S_AXI_ARVALID && !S_AXI_RVALID && !S_AXI_ARREADY;
      if (ar_hs) begin
        S_AXI_RVALID <= 1'b1;
      end else if (S_AXI_RREADY) begin
        S_AXI_RVALID <= 1'b0;
      end
    end
  end

  // capture read data before any FIFO pop lands
  always_ff @(posedge S_AXI_ACLK) begin
    if (ar_hs) begin
      S_AXI_RDATA <= rd_data;
    end
  end

endmodule

`default_nettype wire

// File: rtl/sync_fifo.sv
/*
  single-clock FIFO, payload chosen by type parameter
  head word is visible combinationally, push shows there the next cycle
*/
`timescale 1ns/1ps
`default_nettype none

module sync_fifo #(
  parameter type payload_t = logic [31:0]
) (
  input  logic     S_AXI_ACLK,
  input  logic     S_AXI_ARESETN,
  input  logic     push,
  input  payload_t din,
  input  logic     pop,
  output payload_t dout,
  output logic     full,
  output logic     empty
);
  import spi_pkg::*;

  payload_t  mem [fifo_depth];
  fifo_ptr_t wr_ptr;
  fifo_ptr_t rd_ptr;
  // one bit wider than the pointer so full is distinct from empty
  logic [$bits(fifo_ptr_t):0] count;
  logic do_push;
  logic do_pop;

  assign empty   = (count == '0);
  assign full    = (count == fifo_depth);
  assign dout    = mem[rd_ptr];
  assign do_push = push && !full;
  assign do_pop  = pop && !empty;

  always_ff @(posedge S_AXI_ACLK) begin
    if (!S_AXI_ARESETN) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      // pointers wrap naturally at the depth
      if (do_push) wr_ptr <= wr_ptr + 1'b1;
      if (do_pop) rd_ptr <= rd_ptr + 1'b1;
      if (do_push && !do_pop) begin
        count <= count + 1'b1;
      end else if (do_pop && !do_push) begin
        count <= count - 1'b1;
      end
    end
  end

  always_ff @(posedge S_AXI_ACLK) begin
    if (do_push) mem[wr_ptr] <= din;
  end

endmodule

`default_nettype wire

// File: spi/spi_reg_file.sv
/*
  software visible registers of the SPI host
  starts and ends transfers, defers divide changes, drives FIFO push and pop
*/
`timescale 1ns/1ps
`default_nettype none

module spi_reg_file (
  input  logic                    S_AXI_ACLK,
  input  logic                    S_AXI_ARESETN,
  input  axi_regs_pkg::reg_wr_t   reg_wr,
  input  axi_regs_pkg::reg_rd_t   reg_rd,
  input  logic                    done,
  input  logic                    cmd_full,
  input  logic                    rd_empty,
  input  axi_regs_pkg::axi_data_t rd_head,
  output axi_regs_pkg::axi_data_t rd_data,
  output logic                    busy,
  output spi_pkg::spi_desc_t      desc,
  output spi_pkg::clk_div_t       div_factor,
  output logic                    div_reset,
  output logic                    cmd_push,
  output axi_regs_pkg::axi_data_t cmd_din,
  output logic                    rd_pop
);
  import axi_regs_pkg::*;
  import spi_pkg::*;

  // visible copies, these may change while a transfer runs
  logic      wnr_reg;
  spi_addr_t addr_reg;
  spi_len_t  len_reg;
  clk_div_t  div_reg;
  logic      done_reg;

  // write decode
  logic     wr_wnr;
  logic     wr_addr;
  logic     wr_len;
  logic     wr_wdata;
  logic     wr_div;
  spi_len_t wr_len_val;
  logic     start;
  logic     finish;

  assign wr_wnr     = reg_wr.valid && (reg_wr.idx == reg_spi_wr);
  assign wr_addr    = reg_wr.valid && (reg_wr.idx == reg_spi_address);
  assign wr_len     = reg_wr.valid && (reg_wr.idx == reg_spi_data_len);
  assign wr_wdata   = reg_wr.valid && (reg_wr.idx == reg_spi_write_data);
  assign wr_div     = reg_wr.valid && (reg_wr.idx == reg_clock_divide);
  assign wr_len_val = spi_len_t'(reg_wr.data);

  // nonzero word count while idle kicks off a transfer
  assign start  = wr_len && !busy && (wr_len_val != '0);
  assign finish = busy && done;

  // a full command FIFO drops the word
  assign cmd_push = wr_wdata && !cmd_full;
  assign cmd_din  = reg_wr.data;

  // popping only once the engine can no longer push
  assign rd_pop = reg_rd.valid && (reg_rd.idx == reg_spi_read_data) && !busy && !rd_empty;

  always_ff @(posedge S_AXI_ACLK) begin
    if (!S_AXI_ARESETN) begin
      wnr_reg    <= 1'b0;
      addr_reg   <= '0;
      len_reg    <= '0;
      div_reg    <= '0;
      done_reg   <= 1'b0;
      busy       <= 1'b0;
      div_factor <= '0;
      div_reset  <= 1'b0;
      desc       <= '0;
    end else begin
      div_reset <= 1'b0;
      if (wr_wnr) wnr_reg <= reg_wr.data[0];
      if (wr_addr) addr_reg <= spi_addr_t'(reg_wr.data);
      if (wr_len) len_reg <= wr_len_val;
      if (start) begin
        busy     <= 1'b1;
        done_reg <= 1'b0;
        desc     <= '{wnr: wnr_reg, addr: addr_reg, data_len: wr_len_val};
      end
      // end of transfer, apply any divide factor held back meanwhile
      if (finish) begin
        busy     <= 1'b0;
        done_reg <= 1'b1;
        len_reg  <= '0;
        if (div_factor != div_reg) begin
          div_factor <= div_reg;
          div_reset  <= 1'b1;
        end
      end
      // idle writes go straight to the divider
      if (wr_div) begin
        div_reg <= clk_div_t'(reg_wr.data);
        if (!busy || done) begin
          div_factor <= clk_div_t'(reg_wr.data);
          div_reset  <= 1'b1;
        end
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // read mux, unlisted indexes read zero
  ////////////////////////////////////////////////////////////

  always_comb begin
    case (reg_rd.idx)
      reg_spi_wr:        rd_data = axi_data_t'(wnr_reg);
      reg_spi_address:   rd_data = axi_data_t'(addr_reg);
      reg_spi_data_len:  rd_data = axi_data_t'(len_reg);
      reg_spi_read_data: rd_data = rd_empty ? '0 : rd_head;
      reg_clock_divide:  rd_data = axi_data_t'(div_reg);
      reg_spi_done:      rd_data = axi_data_t'(done_reg);
      default:           rd_data = '0;
    endcase
  end

endmodule

`default_nettype wire

// File: spi/spi_clk_gen.sv
/*
  spi_clk divider, half-period of div_factor+1 ACLK cycles
  ticks flag each edge one cycle ahead for the shift engine
*/
`timescale 1ns/1ps
`default_nettype none

module spi_clk_gen (
  input  logic              S_AXI_ACLK,
  input  logic              S_AXI_ARESETN,
  input  logic              run,
  input  logic              div_reset,
  input  spi_pkg::clk_div_t div_factor,
  output logic              spi_clk,
  output logic              rise_tick,
  output logic              fall_tick
);
  import spi_pkg::*;

  clk_div_t cnt;
  logic     edge_due;

  // spi_clk toggles at the end of this cycle
  assign edge_due  = run && !div_reset && (cnt == div_factor);
  assign rise_tick = edge_due && !spi_clk;
  assign fall_tick = edge_due && spi_clk;

  always_ff @(posedge S_AXI_ACLK) begin
    // idle low whenever stopped
    if (!S_AXI_ARESETN || !run || div_reset) begin
      cnt     <= '0;
      spi_clk <= 1'b0;
    end else if (cnt == div_factor) begin
      cnt     <= '0;
      spi_clk <= ~spi_clk;
    end else begin
      cnt <= cnt + 1'b1;
    end
  end

endmodule

`default_nettype wire

// File: spi/spi_shift_engine.sv
/*
  SPI mode 0 frame engine, MSB first
  sends the header, then shifts write words out or read words in
*/
`timescale 1ns/1ps
`default_nettype none

module spi_shift_engine (
  input  logic                    S_AXI_ACLK,
  input  logic                    S_AXI_ARESETN,
  input  logic                    busy,
  input  spi_pkg::spi_desc_t      desc,
  input  logic                    rise_tick,
  input  logic                    fall_tick,
  input  logic                    poci,
  input  axi_regs_pkg::axi_data_t cmd_dout,
  input  logic                    cmd_empty,
  input  logic                    rd_full,
  output logic                    cmd_pop,
  output logic                    rd_push,
  output axi_regs_pkg::axi_data_t rd_din,
  output logic                    pico,
  output logic                    cs_b,
  output logic                    clk_run,
  output logic                    done
);
  import axi_regs_pkg::*;
  import spi_pkg::*;

  typedef enum logic [1:0] {st_idle, st_hdr, st_data, st_fin} state_t;

  state_t    state;
  bit_cnt_t  bit_cnt;
  spi_len_t  word_cnt;
  axi_data_t tx_sh;
  axi_data_t rx_sh;
  logic      word_end;
  logic      last_word;
  logic      load_pop;
  axi_data_t next_word;

  assign pico      = tx_sh[axi_data_w-1];
  assign word_end  = (state == st_data) && fall_tick && (bit_cnt == bit_cnt_t'(axi_data_w - 1));
  assign last_word = (word_cnt == desc.data_len - spi_len_t'(1));

  // write words from the command FIFO, zeros once it runs dry and for reads
  assign load_pop  = desc.wnr && !cmd_empty;
  assign next_word = load_pop ? cmd_dout : '0;

  always_ff @(posedge S_AXI_ACLK) begin
    if (!S_AXI_ARESETN) begin
      state    <= st_idle;
      bit_cnt  <= '0;
      word_cnt <= '0;
      tx_sh    <= '0;
      cs_b     <= 1'b1;
      clk_run  <= 1'b0;
      done     <= 1'b0;
      cmd_pop  <= 1'b0;
      rd_push  <= 1'b0;
    end else begin
      cmd_pop <= 1'b0;
      rd_push <= 1'b0;
      done    <= 1'b0;
      case (state)
        st_idle: begin
          // done guard keeps the closing cycle from restarting
          if (busy && !done) begin
            cs_b     <= 1'b0;
            clk_run  <= 1'b1;
            bit_cnt  <= '0;
            word_cnt <= '0;
            tx_sh    <= {desc.wnr, desc.addr, {(axi_data_w - hdr_bits){1'b0}}};
            state    <= st_hdr;
          end
        end
        st_hdr: begin
          if (fall_tick && (bit_cnt == bit_cnt_t'(hdr_bits - 1))) begin
            bit_cnt <= '0;
            tx_sh   <= next_word;
            cmd_pop <= load_pop;
            state   <= st_data;
          end else if (fall_tick) begin
            bit_cnt <= bit_cnt + 1'b1;
            tx_sh   <= tx_sh << 1;
          end
        end
        st_data: begin
          if (word_end) begin
            bit_cnt <= '0;
            // a full read FIFO drops the word
            rd_push <= !desc.wnr && !rd_full;
            if (last_word) begin
              cs_b    <= 1'b1;
              clk_run <= 1'b0;
              state   <= st_fin;
            end else begin
              word_cnt <= word_cnt + 1'b1;
              tx_sh    <= next_word;
              cmd_pop  <= load_pop;
            end
          end else if (fall_tick) begin
            bit_cnt <= bit_cnt + 1'b1;
            tx_sh   <= tx_sh << 1;
          end
        end
        default: begin
          // cs_b is already high here
          done  <= 1'b1;
          state <= st_idle;
        end
      endcase
    end
  end

  // poci sampled on rising edges, whole word handed over at its last fall
  always_ff @(posedge S_AXI_ACLK) begin
    if ((state == st_data) && rise_tick) begin
      rx_sh <= {rx_sh[axi_data_w-2:0], poci};
    end
    if (word_end) begin
      rd_din <= rx_sh;
    end
  end

endmodule

`default_nettype wire

// File: rtl/spi_host_top.sv
/*
  top level of the AXI4-Lite controlled SPI host
  connects bus slave, register file, FIFOs, clock divider and shift engine
*/
`timescale 1ns/1ps
`default_nettype none

module spi_host_top (
  input  logic                                S_AXI_ACLK,
  input  logic                                S_AXI_ARESETN,
  input  axi_regs_pkg::axi_addr_t             S_AXI_AWADDR,
  input  logic [2:0]                          S_AXI_AWPROT,
  input  logic                                S_AXI_AWVALID,
  output logic                                S_AXI_AWREADY,
  input  axi_regs_pkg::axi_data_t             S_AXI_WDATA,
  input  logic [axi_regs_pkg::axi_data_w/8-1:0] S_AXI_WSTRB,
  input  logic                                S_AXI_WVALID,
  output logic                                S_AXI_WREADY,
  output axi_regs_pkg::axi_resp_t             S_AXI_BRESP,
  output logic                                S_AXI_BVALID,
  input  logic                                S_AXI_BREADY,
  input  axi_regs_pkg::axi_addr_t             S_AXI_ARADDR,
  input  logic [2:0]                          S_AXI_ARPROT,
  input  logic                                S_AXI_ARVALID,
  output logic                                S_AXI_ARREADY,
  output axi_regs_pkg::axi_data_t             S_AXI_RDATA,
  output axi_regs_pkg::axi_resp_t             S_AXI_RRESP,
  output logic                                S_AXI_RVALID,
  input  logic                                S_AXI_RREADY,
  input  logic                                poci,
  output logic                                pico,
  output logic                                cs_b,
  output logic                                spi_clk
);
  import axi_regs_pkg::*;
  import spi_pkg::*;

  // register strobes
  reg_wr_t   reg_wr;
  reg_rd_t   reg_rd;
  axi_data_t rd_data;

  // transfer control
  logic      busy;
  logic      done;
  spi_desc_t desc;
  clk_div_t  div_factor;
  logic      div_reset;
  logic      clk_run;
  logic      rise_tick;
  logic      fall_tick;

  // command FIFO, software to engine
  logic      cmd_push;
  axi_data_t cmd_din;
  logic      cmd_pop;
  axi_data_t cmd_dout;
  logic      cmd_full;
  logic      cmd_empty;

  // read FIFO, engine to software
  logic      rd_push;
  axi_data_t rd_din;
  logic      rd_pop;
  axi_data_t rd_head;
  logic      rd_full;
  logic      rd_empty;

  axi_lite_slave bus_slave (.*);

  spi_reg_file reg_file (.*);

  sync_fifo #(.payload_t(axi_data_t)) cmd_fifo (
    .S_AXI_ACLK, .S_AXI_ARESETN,
    .push(cmd_push), .din(cmd_din), .pop(cmd_pop),
    .dout(cmd_dout), .full(cmd_full), .empty(cmd_empty)
  );

  sync_fifo #(.payload_t(axi_data_t)) rd_fifo (
    .S_AXI_ACLK, .S_AXI_ARESETN,
    .push(rd_push), .din(rd_din), .pop(rd_pop),
    .dout(rd_head), .full(rd_full), .empty(rd_empty)
  );

  spi_clk_gen clk_gen (
    .S_AXI_ACLK, .S_AXI_ARESETN,
    .run(clk_run), .div_reset, .div_factor,
    .spi_clk, .rise_tick, .fall_tick
  );

  spi_shift_engine shift_engine (.*);

endmodule

`default_nettype wire

// File: verification/spi_periph_model.sv
/*
  behavioral SPI peripheral for the testbench, mode 0, MSB first
  records pico on every spi_clk rise and answers reads from a word list
*/
`timescale 1ns/1ps
`default_nettype none

module spi_periph_model (
  input  logic             spi_clk,
  input  logic             cs_b,
  input  logic             pico,
  input  logic [7:0][31:0] rd_words,
  output logic             poci,
  output logic [127:0]     cap_vec,
  output int               cap_cnt
);
  // direction bit plus ten address bits
  localparam int hdr_len = 11;

  logic         poci_q = 1'b0;
  logic [127:0] vec_q = '0;
  int           cnt_q = 0;
  logic         clk_prev = 1'b0;
  logic         in_frame = 1'b0;
  logic         wnr = 1'b1;
  int           pos;

  assign poci    = poci_q;
  assign cap_vec = vec_q;
  assign cap_cnt = cnt_q;

  always @(posedge spi_clk or negedge spi_clk or posedge cs_b or negedge cs_b) begin
    if (cs_b) begin
      // frame closed, capture stays readable
      in_frame = 1'b0;
    end else begin
      if (!in_frame) begin
        in_frame = 1'b1;
        vec_q    = '0;
        cnt_q    = 0;
        poci_q   = 1'b0;
      end
      if (spi_clk && !clk_prev) begin
        // first bit of a frame is the direction
        if (cnt_q == 0) begin
          wnr = pico;
        end
        vec_q = {vec_q[126:0], pico};
        cnt_q = cnt_q + 1;
      end else if (!spi_clk && clk_prev && !wnr && (cnt_q >= hdr_len)) begin
        // next read bit, settled well before the following rise
        pos    = cnt_q - hdr_len;
        poci_q = rd_words[(pos / 32) % 8][31 - (pos % 32)];
      end
    end
    clk_prev = spi_clk;
  end

endmodule

`default_nettype wire

// File: verification/tb_top.sv
/*
  directed testbench for the AXI4-Lite SPI host
  drives the bus, checks the SPI frames against a peripheral model
*/
`timescale 1ns/1ps
`default_nettype none

module tb_top;
  import axi_regs_pkg::*;
  import spi_pkg::*;

  // per-wait cycle limits
  localparam int hs_limit   = 64;
  localparam int poll_limit = 2000;

  localparam spi_addr_t wr_addr = 10'h2a5;
  localparam spi_addr_t rd_addr = 10'h13c;

  logic      aclk;
  logic      aresetn;
  axi_addr_t awaddr;
  logic      awvalid;
  logic      awready;
  axi_data_t wdata;
  logic [3:0] wstrb;
  logic      wvalid;
  logic      wready;
  axi_resp_t bresp;
  logic      bvalid;
  logic      bready;
  axi_addr_t araddr;
  logic      arvalid;
  logic      arready;
  axi_data_t rdata;
  axi_resp_t rresp;
  logic      rvalid;
  logic      rready;
  logic      poci;
  logic      pico;
  logic      cs_b;
  logic      spi_clk;

  // peripheral model side
  logic [7:0][31:0] peri_words;
  logic [127:0]     cap_vec;
  int               cap_cnt;

  // bookkeeping
  int err_cnt;
  int err_mark;
  int tests_run;
  int tests_failed;

  spi_host_top dut0 (
    .S_AXI_ACLK(aclk), .S_AXI_ARESETN(aresetn),
    .S_AXI_AWADDR(awaddr), .S_AXI_AWPROT(3'b000), .S_AXI_AWVALID(awvalid),
    .S_AXI_AWREADY(awready), .S_AXI_WDATA(wdata), .S_AXI_WSTRB(wstrb),
    .S_AXI_WVALID(wvalid), .S_AXI_WREADY(wready), .S_AXI_BRESP(bresp),
    .S_AXI_BVALID(bvalid), .S_AXI_BREADY(bready), .S_AXI_ARADDR(araddr),
    .S_AXI_ARPROT(3'b000), .S_AXI_ARVALID(arvalid), .S_AXI_ARREADY(arready),
    .S_AXI_RDATA(rdata), .S_AXI_RRESP(rresp), .S_AXI_RVALID(rvalid),
    .S_AXI_RREADY(rready), .poci(poci), .pico(pico), .cs_b(cs_b), .spi_clk(spi_clk)
  );

  spi_periph_model periph (
    .spi_clk(spi_clk), .cs_b(cs_b), .pico(pico), .rd_words(peri_words),
    .poci(poci), .cap_vec(cap_vec), .cap_cnt(cap_cnt)
  );

  // 4 ns ACLK
  initial begin
    aclk = 1'b0;
    forever #2 aclk = ~aclk;
  end

  ////////////////////////////////////////////////////////////
  // reporting
  ////////////////////////////////////////////////////////////

  task automatic abort_run(input string why);
    $display("ERROR at %0t: %s", $time, why);
    $display("Test FAILED");
    $finish;
  endtask

  task automatic check_word(input string what, input axi_data_t got, input axi_data_t exp);
    if (got !== exp) begin
      $display("MISMATCH at %0t: %s got %08h expected %08h", $time, what, got, exp);
      err_cnt++;
    end
  endtask

  task automatic check_resp(input string what, input axi_resp_t got, input axi_resp_t exp);
    if (got !== exp) begin
      $display("MISMATCH at %0t: %s got %0d expected %0d", $time, what, got, exp);
      err_cnt++;
    end
  endtask

  task automatic compare_desc(input string what, input spi_desc_t got, input spi_desc_t exp);
    if (got !== exp) begin
      $display("MISMATCH at %0t: %s got %05h expected %05h", $time, what, got, exp);
      err_cnt++;
    end
  endtask

  task automatic finish_test(input string name);
    tests_run++;
    if (err_cnt == err_mark) begin
      $display("%s: passed", name);
    end else begin
      tests_failed++;
      $display("%s: failed with %0d mismatches", name, err_cnt - err_mark);
    end
    err_mark = err_cnt;
  endtask

  ////////////////////////////////////////////////////////////
  // AXI4-Lite driver, outputs sampled on falling ACLK edges
  ////////////////////////////////////////////////////////////

  task automatic axi_write(input reg_idx_t idx, input axi_data_t data);
    int n;
    @(posedge aclk);
    awaddr  <= axi_addr_t'({idx, 2'b00});
    wdata   <= data;
    wstrb   <= 4'hf;
    awvalid <= 1'b1;
    wvalid  <= 1'b1;
    bready  <= 1'b1;
    n = 0;
    // address and data ready come as one pulse
    do begin
      @(negedge aclk);
      n++;
    end while (!(awready && wready) && (n < hs_limit));
    if (!(awready && wready)) abort_run("write address and data never accepted");
    @(posedge aclk);
    awvalid <= 1'b0;
    wvalid  <= 1'b0;
    n = 0;
    do begin
      @(negedge aclk);
      n++;
    end while (!bvalid && (n < hs_limit));
    if (!bvalid) abort_run("write response never arrived");
    check_resp("write response", bresp, resp_okay);
    @(posedge aclk);
    bready <= 1'b0;
  endtask

  task automatic axi_read(input reg_idx_t idx, output axi_data_t data);
    int n;
    @(posedge aclk);
    araddr  <= axi_addr_t'({idx, 2'b00});
    arvalid <= 1'b1;
    rready  <= 1'b1;
    n = 0;
    do begin
      @(negedge aclk);
      n++;
    end while (!arready && (n < hs_limit));
    if (!arready) abort_run("read address never accepted");
    @(posedge aclk);
    arvalid <= 1'b0;
    n = 0;
    do begin
      @(negedge aclk);
      n++;
    end while (!rvalid && (n < hs_limit));
    if (!rvalid) abort_run("read data never arrived");
    data = rdata;
    check_resp("read response", rresp, resp_okay);
    @(posedge aclk);
    rready <= 1'b0;
  endtask

  // polls the done register until the transfer ends
  task automatic wait_done();
    axi_data_t v;
    int n;
    v = '0;
    n = 0;
    while ((v != 32'd1) && (n < poll_limit)) begin
      axi_read(reg_spi_done, v);
      n++;
    end
    if (v != 32'd1) abort_run("transfer never finished, done stayed low");
  endtask

  // one full high and one full low phase of spi_clk, in ACLK cycles
  task automatic measure_half_periods(output int high_t, output int low_t);
    int n;
    n = 0;
    @(negedge aclk);
    while (spi_clk && (n < hs_limit)) begin
      @(negedge aclk);
      n++;
    end
    while (!spi_clk && (n < hs_limit)) begin
      @(negedge aclk);
      n++;
    end
    if (!spi_clk) abort_run("spi_clk is not toggling during a transfer");
    high_t = 0;
    while (spi_clk && (high_t < hs_limit)) begin
      high_t++;
      @(negedge aclk);
    end
    low_t = 0;
    while (!spi_clk && (low_t < hs_limit)) begin
      low_t++;
      @(negedge aclk);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // directed tests
  ////////////////////////////////////////////////////////////

  task automatic reset_values();
    axi_data_t v;
    int i;
    for (i = 0; i < 9; i++) begin
      axi_read(reg_idx_t'(i), v);
      check_word($sformatf("register %0d after reset", i), v, '0);
    end
    check_word("cs_b after reset", axi_data_t'(cs_b), 32'd1);
    check_word("spi_clk after reset", axi_data_t'(spi_clk), 32'd0);
    axi_write(reg_spi_wr, 32'd1);
    axi_write(reg_spi_address, axi_data_t'(wr_addr));
    axi_write(reg_clock_divide, 32'd3);
    axi_read(reg_spi_wr, v);
    check_word("direction readback", v, 32'd1);
    axi_read(reg_spi_address, v);
    check_word("address readback", v, axi_data_t'(wr_addr));
    axi_read(reg_clock_divide, v);
    check_word("divide readback", v, 32'd3);
  endtask

  task automatic write_frame();
    axi_data_t w0;
    axi_data_t w1;
    spi_desc_t got_d;
    w0 = $urandom();
    w1 = $urandom();
    axi_write(reg_spi_wr, 32'd1);
    axi_write(reg_spi_address, axi_data_t'(wr_addr));
    axi_write(reg_spi_write_data, w0);
    axi_write(reg_spi_write_data, w1);
    axi_write(reg_spi_data_len, 32'd2);
    wait_done();
    check_word("write frame bit count", axi_data_t'(cap_cnt), 32'd75);
    // header and word count rebuilt from the captured frame
    got_d = '{wnr: cap_vec[74], addr: cap_vec[73:64],
              data_len: spi_len_t'((cap_cnt - 11) / 32)};
    compare_desc("write frame header", got_d, '{wnr: 1'b1, addr: wr_addr, data_len: 8'd2});
    check_word("first written word", cap_vec[63:32], w0);
    check_word("second written word", cap_vec[31:0], w1);
  endtask

  task automatic read_frame();
    axi_data_t v;
    spi_desc_t got_d;
    int i;
    for (i = 0; i < 8; i++) begin
      peri_words[i] = $urandom();
    end
    axi_write(reg_spi_wr, 32'd0);
    axi_write(reg_spi_address, axi_data_t'(rd_addr));
    axi_write(reg_spi_data_len, 32'd3);
    wait_done();
    check_word("read frame bit count", axi_data_t'(cap_cnt), 32'd107);
    got_d = '{wnr: cap_vec[106], addr: cap_vec[105:96],
              data_len: spi_len_t'((cap_cnt - 11) / 32)};
    compare_desc("read frame header", got_d, '{wnr: 1'b0, addr: rd_addr, data_len: 8'd3});
    // pico stays low through the data phase of a read
    check_word("pico during read data", cap_vec[95:64] | cap_vec[63:32] | cap_vec[31:0], '0);
    for (i = 0; i < 3; i++) begin
      axi_read(reg_spi_read_data, v);
      check_word($sformatf("read word %0d", i), v, peri_words[i]);
    end
    axi_read(reg_spi_read_data, v);
    check_word("read data after drain", v, '0);
  endtask

  task automatic done_sequence();
    axi_data_t v;
    axi_read(reg_spi_done, v);
    check_word("done after previous transfer", v, 32'd1);
    axi_read(reg_spi_data_len, v);
    check_word("data_len after previous transfer", v, '0);
    // write with an empty command FIFO, zero words go out
    axi_write(reg_spi_wr, 32'd1);
    axi_write(reg_spi_data_len, 32'd1);
    axi_read(reg_spi_done, v);
    check_word("done while busy", v, '0);
    axi_read(reg_spi_data_len, v);
    check_word("data_len while busy", v, 32'd1);
    wait_done();
    axi_read(reg_spi_data_len, v);
    check_word("data_len at end", v, '0);
    check_word("empty FIFO write bit count", axi_data_t'(cap_cnt), 32'd43);
    check_word("empty FIFO write word", cap_vec[31:0], '0);
  endtask

  task automatic divide_timing();
    int hi;
    int lo;
    axi_write(reg_spi_wr, 32'd1);
    axi_write(reg_clock_divide, 32'd0);
    axi_write(reg_spi_data_len, 32'd1);
    measure_half_periods(hi, lo);
    check_word("spi_clk high time, factor 0", axi_data_t'(hi), 32'd1);
    check_word("spi_clk low time, factor 0", axi_data_t'(lo), 32'd1);
    wait_done();
    axi_write(reg_clock_divide, 32'd3);
    axi_write(reg_spi_data_len, 32'd1);
    measure_half_periods(hi, lo);
    check_word("spi_clk high time, factor 3", axi_data_t'(hi), 32'd4);
    check_word("spi_clk low time, factor 3", axi_data_t'(lo), 32'd4);
    // held back until this transfer ends
    axi_write(reg_clock_divide, 32'd0);
    measure_half_periods(hi, lo);
    check_word("spi_clk high time, deferred factor", axi_data_t'(hi), 32'd4);
    check_word("spi_clk low time, deferred factor", axi_data_t'(lo), 32'd4);
    wait_done();
    axi_write(reg_spi_data_len, 32'd1);
    measure_half_periods(hi, lo);
    check_word("spi_clk high time, applied factor", axi_data_t'(hi), 32'd1);
    check_word("spi_clk low time, applied factor", axi_data_t'(lo), 32'd1);
    wait_done();
  endtask

  ////////////////////////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////////////////////////

  initial begin
    void'($urandom(92701));
    err_cnt      = 0;
    err_mark     = 0;
    tests_run    = 0;
    tests_failed = 0;
    peri_words   = '0;
    aresetn <= 1'b0;
    awaddr  <= '0;
    awvalid <= 1'b0;
    wdata   <= '0;
    wstrb   <= '0;
    wvalid  <= 1'b0;
    bready  <= 1'b0;
    araddr  <= '0;
    arvalid <= 1'b0;
    rready  <= 1'b0;
    repeat (8) @(posedge aclk);
    aresetn <= 1'b1;
    @(posedge aclk);

    reset_values();
    finish_test("reset values and readback");
    write_frame();
    finish_test("write transfer of two words");
    read_frame();
    finish_test("read transfer of three words");
    done_sequence();
    finish_test("done and data_len tracking");
    divide_timing();
    finish_test("clock divide and deferred factor");

    $display("tests run %0d, failed %0d, mismatches %0d", tests_run, tests_failed, err_cnt);
    if (tests_failed == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: list.f
common/axi_regs_pkg.sv
common/spi_pkg.sv
rtl/axi_lite_slave.sv
rtl/sync_fifo.sv
spi/spi_reg_file.sv
spi/spi_clk_gen.sv
spi/spi_shift_engine.sv
rtl/spi_host_top.sv
verification/spi_periph_model.sv
verification/tb_top.sv

// File: run_sim.sh
#!/bin/sh
# build the SPI host testbench with Verilator and run it
# exit status is nonzero when the build, the run or the check fails

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module tb_top -f list.f -o tb_sim > build.log 2>&1
if [ $? -ne 0 ]; then
  echo "build failed, see build.log"
  exit 1
fi

./obj_dir/tb_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

# the log decides the verdict
if grep -q "^Test OK$" sim.log; then
  exit 0
fi
echo "pass message not found in sim.log"
exit 1
